// ==== all.f ====
+incdir+testbench
common/analog_pkg.sv
common/stream_if.sv
verilog/dac_mix.sv
verilog/adc_decode.sv
verilog/dac_encode.sv
verilog/analog_io_top.sv
testbench/tb_analog_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the analog path testbench with Verilator.
# Exit status is zero only when the pass message is printed.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_analog_io \
  --Mdir obj_dir -o tb_analog_io \
  -f all.f

out=$(./obj_dir/tb_analog_io)
echo "$out"

if echo "$out" | grep -q "^Simulation completed successfully$"; then
  exit 0
fi
exit 1

// ==== testbench/tb_analog_io_tasks.svh ====
////////////////////
// LFSR, drive tasks and tests for tb_analog_io
// Every task starts and ends on a falling adc_clk edge
////////////////////

`ifndef TB_ANALOG_IO_TASKS_SVH
`define TB_ANALOG_IO_TASKS_SVH

  ////////////////////
  // Random source
  ////////////////////

  // Galois LFSR, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        out_bit;
    v = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr[0];
      lfsr    = out_bit ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v       = {v[30:0], out_bit};
    end
    return v;
  endfunction

  function automatic analog_pkg::sample_t rand_sample();
    return analog_pkg::sample_t'(rand_bits(analog_pkg::SAMPLE_W));
  endfunction

  function automatic analog_pkg::adc_raw_t rand_raw();
    return analog_pkg::adc_raw_t'(rand_bits(analog_pkg::ADC_RAW_W));
  endfunction

  ////////////////////
  // Drive
  ////////////////////

  // One cycle; sink ready high one time in four when randomized
  task automatic next_cycle();
    @(negedge adc_clk);
    if (rand_ready) begin
      out_ready_i = (rand_bits(2) == 32'd0);
    end
  endtask

  // Hold one item until accepted
  task automatic send_item(input analog_pkg::adc_raw_t raw_a, input analog_pkg::adc_raw_t raw_b,
                           input analog_pkg::sample_t asg_a, input analog_pkg::sample_t asg_b,
                           input analog_pkg::sample_t pid_a, input analog_pkg::sample_t pid_b,
                           input logic loop);
    int target;
    target         = in_cnt + 1;
    in_valid_i     = 1'b1;
    adc_raw_a_i    = raw_a;
    adc_raw_b_i    = raw_b;
    asg_a_i        = asg_a;
    asg_b_i        = asg_b;
    pid_a_i        = pid_a;
    pid_b_i        = pid_b;
    digital_loop_i = loop;
    do next_cycle(); while (in_cnt < target);
  endtask

  task automatic send_random(input logic loop);
    send_item(rand_raw(), rand_raw(), rand_sample(), rand_sample(), rand_sample(),
              rand_sample(), loop);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_base = err_cnt;
    txn_base = in_cnt;
  endtask

  // Drain, then one report line
  task automatic finish_test();
    in_valid_i = 1'b0;
    while (out_cnt < in_cnt) next_cycle();
    tests_run++;
    $display("Test %s done: %0d transactions, %0d errors", cur_test, in_cnt - txn_base,
             err_cnt - err_base);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    start_test("reset");
    repeat (4) next_cycle();  // Reset state checked on release
    finish_test();
  endtask

  task automatic test_adc_decode();
    analog_pkg::adc_raw_t corner [4];
    analog_pkg::adc_raw_t r;
    corner = '{16'h0000, 16'hffff, 16'h8000, 16'h7fff};
    start_test("adc_decode");
    foreach (corner[i]) begin
      send_item(corner[i], corner[3 - i], rand_sample(), rand_sample(), rand_sample(),
                rand_sample(), 1'b0);
    end
    // Same upper bits, LSBs 00 then 11
    repeat (2) begin
      r = rand_raw();
      send_item(r & ~16'h0003, r | 16'h0003, '0, '0, '0, '0, 1'b0);
      send_item(r | 16'h0003, r & ~16'h0003, '0, '0, '0, '0, 1'b0);
    end
    repeat (24) send_random(1'b0);
    finish_test();
  endtask

  task automatic test_mix_sat();
    int ga [8];
    int pa [8];
    ga = '{8191, 5000, -8192, -6000, 4000, -4096, 8191, -8192};  // Over, under, limits
    pa = '{1, 5000, -1, -6000, 4191, -4096, 0, 0};
    start_test("mix_sat");
    for (int i = 0; i < 8; i++) begin
      send_item(rand_raw(), rand_raw(),
                analog_pkg::sample_t'(ga[i]), analog_pkg::sample_t'(ga[(i + 4) % 8]),
                analog_pkg::sample_t'(pa[i]), analog_pkg::sample_t'(pa[(i + 4) % 8]), 1'b0);
    end
    repeat (24) send_random(1'b0);
    finish_test();
  endtask

  // Setting flips while the previous burst is still in flight
  task automatic test_loopback();
    start_test("loopback");
    for (int b = 0; b < 4; b++) begin
      repeat (6) send_random(b % 2 == 0);
    end
    finish_test();
  endtask

  task automatic test_latency();
    start_test("latency");
    out_ready_i = 1'b1;
    lat_mode    = 1'b1;
    repeat (N_LATENCY) send_random(1'b0);
    finish_test();
    lat_mode = 1'b0;
  endtask

  task automatic test_backpressure();
    int stalls_before;
    start_test("backpressure");
    stalls_before = stall_cnt;
    rand_ready    = 1'b1;
    repeat (N_BACKPRESS) send_random(rand_bits(1) == 32'd1);
    assert (stall_cnt > stalls_before)
      else event_error("in_ready_o never dropped under back-pressure");
    finish_test();
    rand_ready  = 1'b0;
    out_ready_i = 1'b1;
  endtask

`endif

// ==== testbench/tb_analog_io.sv ====
////////////////////
// Testbench for analog_io_top in its single adc_clk domain
// Concurrent assertions compare each output with a queue model
// Stimulus on falling edges and a cycle limit on the whole run
////////////////////

`timescale 1ns/1ps

module tb_analog_io;

  ////////////////////
  // Run length
  ////////////////////

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned N_DECODE     = 32;  // 4 corners, 2 LSB pairs, 24 random
  localparam int unsigned N_MIX        = 32;  // 8 corners, 24 random
  localparam int unsigned N_LOOP       = 24;  // 4 bursts of 6
  localparam int unsigned N_LATENCY    = 16;
  localparam int unsigned N_BACKPRESS  = 48;
  localparam int unsigned TOTAL_TXN    = N_DECODE + N_MIX + N_LOOP + N_LATENCY + N_BACKPRESS;
  localparam int unsigned CYCLE_LIMIT  = TOTAL_TXN * 8 + RESET_CYCLES + 100;

  // Expected output of one transaction
  typedef struct packed {
    analog_pkg::sample_t   adc_a;
    analog_pkg::sample_t   adc_b;
    analog_pkg::dac_code_t dac_a;
    analog_pkg::dac_code_t dac_b;
    int unsigned           acc_cyc;  // Edge count at accept
  } exp_t;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                  adc_clk = 1'b0;
  logic                  rst_n_i;
  logic                  digital_loop_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  analog_pkg::adc_raw_t  adc_raw_a_i;
  analog_pkg::adc_raw_t  adc_raw_b_i;
  analog_pkg::sample_t   asg_a_i;
  analog_pkg::sample_t   asg_b_i;
  analog_pkg::sample_t   pid_a_i;
  analog_pkg::sample_t   pid_b_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  analog_pkg::sample_t   adc_a_o;
  analog_pkg::sample_t   adc_b_o;
  analog_pkg::dac_code_t dac_a_o;
  analog_pkg::dac_code_t dac_b_o;

  // Scoreboard and run state
  exp_t        exp_q [$];       // Accepted but not yet output
  exp_t        exp_cur;         // Front of queue, seen by the assertions
  logic        exp_valid = 1'b0;
  int unsigned cyc       = 0;
  int          in_cnt    = 0;
  int          out_cnt   = 0;
  int          stall_cnt = 0;   // Cycles with input held off
  int          err_cnt   = 0;
  int          tests_run = 0;
  int          err_base  = 0;
  int          txn_base  = 0;
  string       cur_test  = "none";
  logic        lat_mode  = 1'b0;  // Latency check armed
  logic        rand_ready = 1'b0; // Random out_ready_i per cycle
  logic [31:0] lfsr      = 32'hf3ad;

  always #2 adc_clk = ~adc_clk;  // 4 ns period

  analog_io_top dut0 (.*);

  ////////////////////
  // Reference model
  ////////////////////

  // Clamp to the 14-bit range
  function automatic analog_pkg::sample_t sat_sum(input analog_pkg::sample_t a,
                                                  input analog_pkg::sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > int'(analog_pkg::SAMPLE_MAX)) s = int'(analog_pkg::SAMPLE_MAX);
    if (s < int'(analog_pkg::SAMPLE_MIN)) s = int'(analog_pkg::SAMPLE_MIN);
    return analog_pkg::sample_t'(s);
  endfunction

  // Raw bits 15:2, sign kept, rest inverted
  function automatic analog_pkg::sample_t adc_expect(input analog_pkg::adc_raw_t raw);
    logic [13:0] w;
    w = raw[15:2];
    return {w[13], ~w[12:0]};
  endfunction

  function automatic analog_pkg::dac_code_t dac_expect(input analog_pkg::sample_t s);
    return {s[13], ~s[12:0]};  // Negative slope
  endfunction

  always @(posedge adc_clk) begin
    exp_t                nxt;
    analog_pkg::sample_t sum_a;
    analog_pkg::sample_t sum_b;
    cyc <= cyc + 1;
    if (!rst_n_i) begin
      exp_q.delete();
    end else begin
      if (out_valid_o && out_ready_i) begin
        out_cnt <= out_cnt + 1;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (in_valid_i && in_ready_o) begin
        sum_a       = sat_sum(asg_a_i, pid_a_i);
        sum_b       = sat_sum(asg_b_i, pid_b_i);
        nxt.adc_a   = digital_loop_i ? sum_a : adc_expect(adc_raw_a_i);
        nxt.adc_b   = digital_loop_i ? sum_b : adc_expect(adc_raw_b_i);
        nxt.dac_a   = dac_expect(sum_a);
        nxt.dac_b   = dac_expect(sum_b);
        nxt.acc_cyc = cyc;
        exp_q.push_back(nxt);
        in_cnt <= in_cnt + 1;
      end
      if (in_valid_i && !in_ready_o) begin
        stall_cnt <= stall_cnt + 1;  // Pipeline full
      end
    end
    exp_valid <= (exp_q.size() > 0);
    if (exp_q.size() > 0) begin
      exp_cur <= exp_q[0];
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic value_mismatch(input string what, input logic [13:0] expv,
                                input logic [13:0] actv);
    err_cnt++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, expv, actv);
  endtask

  task automatic event_error(input string what);
    err_cnt++;
    $display("Error in test %s: %s", cur_test, what);
  endtask

  a_reset_state: assert property (@(posedge adc_clk)
    $rose(rst_n_i) |-> !out_valid_o && in_ready_o)
    else event_error("pipeline not empty and ready right after reset");

  a_adc_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> adc_a_o == exp_cur.adc_a)
    else value_mismatch("adc_a_o", $sampled(exp_cur.adc_a), $sampled(adc_a_o));

  a_adc_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> adc_b_o == exp_cur.adc_b)
    else value_mismatch("adc_b_o", $sampled(exp_cur.adc_b), $sampled(adc_b_o));

  a_dac_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> dac_a_o == exp_cur.dac_a)
    else value_mismatch("dac_a_o", $sampled(exp_cur.dac_a), $sampled(dac_a_o));

  a_dac_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> dac_b_o == exp_cur.dac_b)
    else value_mismatch("dac_b_o", $sampled(exp_cur.dac_b), $sampled(dac_b_o));

  // Extra outputs would show up with nothing queued
  a_no_extra: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> exp_valid)
    else event_error("output transfer with no input pending");

  // Output held by the sink keeps valid and data
  a_out_stable: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable({adc_a_o, adc_b_o, dac_a_o, dac_b_o}))
    else event_error("held output dropped or changed before the sink took it");

  a_latency: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    lat_mode && out_valid_o && out_ready_i |-> cyc - exp_cur.acc_cyc == 3)
    else value_mismatch("latency", 14'd3, 14'($sampled(cyc - exp_cur.acc_cyc)));

  // Hang guard
  always @(posedge adc_clk) begin
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles in test %s", cyc, cur_test);
      $display("Simulation failed");
      $finish;
    end
  end

  `include "tb_analog_io_tasks.svh"

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n_i        = 1'b0;
    digital_loop_i = 1'b0;
    in_valid_i     = 1'b0;
    adc_raw_a_i    = '0;
    adc_raw_b_i    = '0;
    asg_a_i        = '0;
    asg_b_i        = '0;
    pid_a_i        = '0;
    pid_b_i        = '0;
    out_ready_i    = 1'b1;
    repeat (RESET_CYCLES) @(negedge adc_clk);
    rst_n_i = 1'b1;
    test_reset();
    test_adc_decode();
    test_mix_sat();
    test_loopback();
    test_latency();
    test_backpressure();
    $display("Tests: %0d, transactions in: %0d, out: %0d, errors: %0d",
             tests_run, in_cnt, out_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/analog_io_top.sv ====
////////////////////
// Analog sample path top: mix, ADC decode, DAC encode
// Single adc_clk domain, synchronous active-low reset
// Three-cycle latency with out_ready_i high
// Channel A is index 0, channel B index 1
////////////////////

`timescale 1ns/1ps

module analog_io_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // Configuration
  input  logic                  digital_loop_i,  // ADC replaced by DAC value
  // Input transaction
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  analog_pkg::adc_raw_t  adc_raw_a_i,     // Raw ADC words
  input  analog_pkg::adc_raw_t  adc_raw_b_i,
  input  analog_pkg::sample_t   asg_a_i,         // Generator samples
  input  analog_pkg::sample_t   asg_b_i,
  input  analog_pkg::sample_t   pid_a_i,         // Feedback samples
  input  analog_pkg::sample_t   pid_b_i,
  // Output transaction
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output analog_pkg::sample_t   adc_a_o,         // Decoded ADC
  output analog_pkg::sample_t   adc_b_o,
  output analog_pkg::dac_code_t dac_a_o,         // DAC codes
  output analog_pkg::dac_code_t dac_b_o
);

  ////////////////////
  // Channel vectors
  ////////////////////

  analog_pkg::adc_raw_t  [analog_pkg::N_CH-1:0] adc_raw;
  analog_pkg::sample_t   [analog_pkg::N_CH-1:0] asg;
  analog_pkg::sample_t   [analog_pkg::N_CH-1:0] pid;
  analog_pkg::sample_t   [analog_pkg::N_CH-1:0] adc;
  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] dac;

  assign adc_raw[0] = adc_raw_a_i;
  assign adc_raw[1] = adc_raw_b_i;
  assign asg[0]     = asg_a_i;
  assign asg[1]     = asg_b_i;
  assign pid[0]     = pid_a_i;
  assign pid[1]     = pid_b_i;

  assign adc_a_o    = adc[0];
  assign adc_b_o    = adc[1];
  assign dac_a_o    = dac[0];
  assign dac_b_o    = dac[1];

  ////////////////////
  // Stage links
  ////////////////////

  mix_if mix_bus ();  // Stage 1 to 2
  dec_if dec_bus ();  // Stage 2 to 3

  ////////////////////
  // Stages
  ////////////////////

  // Sum and saturate
  dac_mix dac_mix0 (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .digital_loop_i (digital_loop_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .adc_raw_i      (adc_raw),
    .asg_i          (asg),
    .pid_i          (pid),
    .out            (mix_bus.src)
  );

  // ADC offset code to two's complement, loopback select
  adc_decode adc_decode0 (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .in      (mix_bus.dst),
    .out     (dec_bus.src)
  );

  // Negative-slope DAC code, output register
  dac_encode dac_encode0 (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .in          (dec_bus.dst),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .adc_o       (adc),
    .dac_o       (dac)
  );

endmodule

// ==== verilog/dac_encode.sv ====
////////////////////
// Stage 3: mix sample to negative-slope DAC code
// Presents the output transaction on plain ports
////////////////////

`timescale 1ns/1ps

module dac_encode (
  input  logic                                         adc_clk,
  input  logic                                         rst_n_i,
  dec_if.dst                                           in,
  output logic                                         out_valid_o,
  input  logic                                         out_ready_i,
  output analog_pkg::sample_t   [analog_pkg::N_CH-1:0] adc_o,
  output analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] dac_o
);

  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] dac_code;
  logic                                         take;

  ////////////////////
  // Encode
  ////////////////////

  // Sign bit kept, lower 13 inverted; +max maps to code 0x0000
  always_comb begin
    for (int ch = 0; ch < analog_pkg::N_CH; ch++) begin
      dac_code[ch] = {in.mix[ch][analog_pkg::SAMPLE_W-1],
                      ~in.mix[ch][analog_pkg::SAMPLE_W-2:0]};
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  assign in.ready = ~out_valid_o | out_ready_i;
  assign take     = in.valid & in.ready;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in.ready) begin
      out_valid_o <= in.valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (take) begin
      adc_o <= in.adc;
      dac_o <= dac_code;
    end
  end

  // Held output stays put until the sink takes it
  a_out_hold: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(adc_o) && $stable(dac_o));

  // Pipeline comes up empty
  a_rst_empty: assert property (@(posedge adc_clk)
    !rst_n_i |=> !out_valid_o);

endmodule

// ==== verilog/adc_decode.sv ====
////////////////////
// Stage 2: ADC word to two's complement, loopback select
// Bits 1:0 of the raw word are dropped
// ADC is negative-slope offset code
////////////////////

`timescale 1ns/1ps

module adc_decode (
  input  logic adc_clk,
  input  logic rst_n_i,
  mix_if.dst   in,
  dec_if.src   out
);

  analog_pkg::sample_t [analog_pkg::N_CH-1:0] adc_word;  // Raw 15:2, still offset code
  analog_pkg::sample_t [analog_pkg::N_CH-1:0] adc_dec;   // After sign handling and loop
  logic                                       take;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    for (int ch = 0; ch < analog_pkg::N_CH; ch++) begin
      // Drop reserved LSBs
      adc_word[ch] = in.adc_raw[ch][analog_pkg::ADC_RAW_W-1:analog_pkg::ADC_DROP_LSB];
      if (in.loop) begin
        adc_dec[ch] = in.mix[ch];  // Digital loopback, DAC value seen as ADC
      end else begin
        // Keep sign bit, invert magnitude bits
        adc_dec[ch] = {adc_word[ch][analog_pkg::SAMPLE_W-1],
                       ~adc_word[ch][analog_pkg::SAMPLE_W-2:0]};
      end
    end
  end

  ////////////////////
  // Register stage
  ////////////////////

  assign in.ready = ~out.valid | out.ready;
  assign take     = in.valid & in.ready;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      out.valid <= 1'b0;
    end else if (in.ready) begin
      out.valid <= in.valid;  // Bubble when upstream empty
    end
  end

  always_ff @(posedge adc_clk) begin
    if (take) begin
      out.adc <= adc_dec;
      out.mix <= in.mix;  // Passed on for DAC encoding
    end
  end

  // Back-pressure from stage 3 freezes this stage
  a_stall: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out.valid && !out.ready |=> out.valid && $stable(out.adc) && $stable(out.mix));

endmodule

// ==== verilog/dac_mix.sv ====
////////////////////
// Stage 1: ASG + PID per channel, saturated to 14 bits
// Raw ADC words and loopback flag ride along untouched
// One-entry register stage, one cycle of latency
////////////////////

`timescale 1ns/1ps

module dac_mix (
  input  logic                                        adc_clk,
  input  logic                                        rst_n_i,
  input  logic                                        digital_loop_i,  // Sampled per item
  input  logic                                        in_valid_i,
  output logic                                        in_ready_o,
  input  analog_pkg::adc_raw_t [analog_pkg::N_CH-1:0] adc_raw_i,
  input  analog_pkg::sample_t  [analog_pkg::N_CH-1:0] asg_i,
  input  analog_pkg::sample_t  [analog_pkg::N_CH-1:0] pid_i,
  mix_if.src                                          out
);

  analog_pkg::sum_t    [analog_pkg::N_CH-1:0] sum;  // Full 15-bit sums
  analog_pkg::sample_t [analog_pkg::N_CH-1:0] sat;  // Clamped to 14 bits
  logic                                       take;

  ////////////////////
  // Sum and saturation
  ////////////////////

  always_comb begin
    for (int ch = 0; ch < analog_pkg::N_CH; ch++) begin
      // Sign-extend both operands by one bit
      sum[ch] = {asg_i[ch][analog_pkg::SAMPLE_W-1], asg_i[ch]}
              + {pid_i[ch][analog_pkg::SAMPLE_W-1], pid_i[ch]};
      if (sum[ch][analog_pkg::SUM_W-1] != sum[ch][analog_pkg::SUM_W-2]) begin  // Overflow
        sat[ch] = sum[ch][analog_pkg::SUM_W-1] ? analog_pkg::SAMPLE_MIN
                                               : analog_pkg::SAMPLE_MAX;
      end else begin
        sat[ch] = sum[ch][analog_pkg::SAMPLE_W-1:0];  // Fits, drop guard bit
      end
    end
  end

  ////////////////////
  // Register stage
  ////////////////////

  assign in_ready_o = ~out.valid | out.ready;  // Empty, or item leaving now
  assign take       = in_valid_i & in_ready_o;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      out.valid <= 1'b0;
    end else if (in_ready_o) begin
      out.valid <= in_valid_i;
    end
  end

  // Payload, loaded only on accept
  always_ff @(posedge adc_clk) begin
    if (take) begin
      out.adc_raw <= adc_raw_i;
      out.mix     <= sat;
      out.loop    <= digital_loop_i;  // Loopback follows its own item
    end
  end

  // Stalled item must hold until stage 2 takes it
  a_hold: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    out.valid && !out.ready |=> out.valid && $stable(out.adc_raw) && $stable(out.mix)
                                && $stable(out.loop));

endmodule

// ==== common/stream_if.sv ====
////////////////////
// Valid/ready links between the pipeline stages
// Transfer on adc_clk edge with valid and ready both high
// Source holds valid and data until that transfer
////////////////////

`timescale 1ns/1ps

// Stage 1 to stage 2: raw ADC words, saturated mix, loopback flag
interface mix_if;
  logic                                          valid;
  logic                                          ready;
  analog_pkg::adc_raw_t [analog_pkg::N_CH-1:0]   adc_raw;  // Undecoded ADC words
  analog_pkg::sample_t  [analog_pkg::N_CH-1:0]   mix;      // Saturated ASG + PID
  logic                                          loop;     // Digital loopback for this item

  modport src (output valid, output adc_raw, output mix, output loop, input ready);
  modport dst (input valid, input adc_raw, input mix, input loop, output ready);
endinterface

// Stage 2 to stage 3: decoded ADC samples and mix samples
interface dec_if;
  logic                                          valid;
  logic                                          ready;
  analog_pkg::sample_t  [analog_pkg::N_CH-1:0]   adc;  // Decoded, or mix in loopback
  analog_pkg::sample_t  [analog_pkg::N_CH-1:0]   mix;  // Still to be DAC encoded

  modport src (output valid, output adc, output mix, input ready);
  modport dst (input valid, input adc, input mix, output ready);
endinterface

// ==== common/analog_pkg.sv ====
////////////////////
// Widths and sample types for the two-channel analog path
// Channel count is fixed at two by the top-level ports
// Samples are 14-bit signed; DAC codes are negative-slope offset binary
////////////////////

package analog_pkg;

  ////////////////////
  // Channel and word widths
  ////////////////////

  localparam int unsigned N_CH         = 2;   // Channels A and B
  localparam int unsigned ADC_RAW_W    = 16;  // Raw ADC bus word
  localparam int unsigned ADC_DROP_LSB = 2;   // Reserved LSBs of 16-bit ADC word
  localparam int unsigned SAMPLE_W     = 14;  // Signed sample width
  localparam int unsigned SUM_W        = SAMPLE_W + 1;  // One guard bit for ASG + PID

  ////////////////////
  // Sample types
  ////////////////////

  // Raw word as seen on the ADC pins, low two bits unused
  typedef logic [ADC_RAW_W-1:0] adc_raw_t;

  // Two's complement sample, used for ADC, ASG, PID and mix values
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Unsaturated sum of generator and feedback
  typedef logic signed [SUM_W-1:0] sum_t;

  // DAC code, sign bit kept and lower bits inverted
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  ////////////////////
  // Saturation limits
  ////////////////////

  // Full-scale positive, 0x1FFF
  localparam sample_t SAMPLE_MAX = sample_t'(8191);

  // Full-scale negative, 0x2000
  localparam sample_t SAMPLE_MIN = sample_t'(-8192);

  // Sum overflows 14 bits when its two top bits disagree;
  // the top bit then tells which limit applies

endpackage
